// File: logic/world_params.svh
`ifndef WORLD_PARAMS_SVH
`define WORLD_PARAMS_SVH

// Coordinate and extent widths
`define COORD_W 13
`define SIZE_W 11

// Object counts on the stage
`define BOX_NUM 8
`define COIN_NUM 4

// Stage geometry, y is always the bottom row of an object
`define TILE 40
`define GROUND_Y 440
`define MAP_WIDTH 2000
`define CASTLE_X 1800
`define CASTLE_Y 439
`define CASTLE_W 479
`define CASTLE_H 360

// Hero
`define HERO_START_X 100
`define HERO_START_Y 439
`define HERO_W 32
`define HERO_H_SMALL 40
`define HERO_H_BIG 80
`define JUMP_LIMIT 127 // Steps of rising before the fall

// Score per event
`define COIN_PTS 5
`define MUSH_PTS 20

// Step rate and scrolling
`define STEP_DIV 8
`define VIEW_LEFT 310
`define SCREEN_W 640

`endif

// File: logic/world_pkg.sv
`default_nettype none

`include "world_params.svh"

package world_pkg;

	typedef logic [`COORD_W-1:0] coord_t; // World x or y
	typedef logic [`SIZE_W-1:0] size_t; // Width, height or offset inside an object

	typedef logic [$clog2(`BOX_NUM)-1:0] box_idx_t;
	typedef logic [$clog2(`COIN_NUM+1)-1:0] coin_cnt_t; // Coins taken in one step

	typedef enum logic [1:0] {
		coin_box = 2'd0,
		mushroom_box = 2'd1,
		empty_box = 2'd2,
		brick_box = 2'd3
	} box_kind_e;

	// Tile kinds seen by the renderer
	typedef enum logic [5:0] {
		box_full = 6'd0,
		box_empty = 6'd1,
		hero_small = 6'd2,
		hero_big = 6'd3,
		coin = 6'd4,
		brick = 6'd8,
		ground = 6'd13,
		castle = 6'd25,
		sky = 6'd63 // Background colour
	} tile_e;

	typedef enum logic [1:0] {standing, rising, falling} jump_e;

	typedef enum logic {play = 1'b0, win = 1'b1} game_e;

endpackage

`default_nettype wire

// File: logic/step_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "world_params.svh"

module step_timer #(
	parameter int div = `STEP_DIV
) (
	input wire clkdiv,
	input wire rstn,
	input wire jump,
	input wire left,
	input wire right,
	output logic step,
	output logic left_held,
	output logic right_held,
	output logic jump_held
);

	localparam int cnt_w = (div > 1) ? $clog2(div) : 1;

	logic [cnt_w-1:0] cnt;
	logic [2:0] btn; // jump, left, right
	logic [2:0] held;

	assign btn = {jump, left, right};

	// Step pulse every div cycles
	always_ff @(posedge clkdiv) begin
		if (rstn) begin
			cnt <= cnt_w'(div - 1);
			step <= 1'b0;
		end else begin
			step <= (cnt == '0);
			if (cnt == '0)
				cnt <= cnt_w'(div - 1); // Reload
			else
				cnt <= cnt - 1'b1;
		end
	end

	// Sticky presses, restarted right after each step
	always_ff @(posedge clkdiv) begin
		if (rstn)
			held <= '0;
		else if (step)
			held <= btn;
		else
			held <= held | btn;
	end

	assign {jump_held, left_held, right_held} = held;

endmodule

`default_nettype wire

// File: logic/stage_layout.sv
`timescale 1ns/100ps
`default_nettype none

`include "world_params.svh"

module stage_layout (
	input wire clkdiv,
	input wire rstn,
	input wire world_pkg::coord_t probe_x,
	input wire world_pkg::coord_t probe_y,
	input wire world_pkg::size_t probe_w,
	input wire world_pkg::size_t probe_h,
	output logic blocked,
	output logic hit_box,
	output world_pkg::box_idx_t hit_index,
	output world_pkg::box_kind_e hit_kind,
	input wire strike,
	input wire world_pkg::box_idx_t strike_index,
	input wire step,
	input wire world_pkg::coord_t hero_x,
	input wire world_pkg::coord_t hero_y,
	input wire world_pkg::size_t hero_h,
	output world_pkg::coin_cnt_t coin_taken,
	input wire world_pkg::coord_t pix_x,
	input wire world_pkg::coord_t pix_y,
	output logic pix_hit,
	output world_pkg::tile_e pix_tile,
	output world_pkg::size_t pix_rel_w,
	output world_pkg::size_t pix_rel_h
);

	localparam world_pkg::size_t tile_sz = `TILE;
	localparam world_pkg::size_t hero_w = `HERO_W;

	////////////////////////////////////////
	// Fixed stage tables, 0,0 marks an unused box
	localparam world_pkg::coord_t box_x [`BOX_NUM] = '{200, 400, 240, 600, 0, 0, 0, 0};
	localparam world_pkg::coord_t box_y [`BOX_NUM] = '{300, 300, 300, 300, 0, 0, 0, 0};
	localparam world_pkg::box_kind_e box_init [`BOX_NUM] = '{
		world_pkg::coin_box, world_pkg::mushroom_box,
		world_pkg::brick_box, world_pkg::brick_box,
		world_pkg::brick_box, world_pkg::brick_box,
		world_pkg::brick_box, world_pkg::brick_box
	};
	localparam world_pkg::coord_t coin_x [`COIN_NUM] = '{160, 800, 1000, 1200};
	localparam world_pkg::coord_t coin_y [`COIN_NUM] = '{439, 439, 439, 439};

	world_pkg::box_kind_e kind [`BOX_NUM];
	logic [`COIN_NUM-1:0] coin_present;
	logic [`COIN_NUM-1:0] touched;
	world_pkg::coin_cnt_t touched_cnt;
	logic wall_hit;

	function automatic logic box_used(input int i);
		return (box_x[i] != '0) || (box_y[i] != '0);
	endfunction

	// Rectangles given by left column and bottom row
	function automatic logic overlap(
		input world_pkg::coord_t x1, y1, input world_pkg::size_t w1, h1,
		input world_pkg::coord_t x2, y2, input world_pkg::size_t w2, h2);
		return (x1 + w1 > x2) && (x2 + w2 > x1) && (y1 < y2 + h1) && (y2 < y1 + h2);
	endfunction

	function automatic logic in_tile(input world_pkg::coord_t x, y, bx, by);
		return (y + tile_sz > by) && (y <= by) && (x >= bx) && (x < bx + tile_sz);
	endfunction

	function automatic world_pkg::tile_e box_tile(input world_pkg::box_kind_e k);
		case (k)
			world_pkg::empty_box: return world_pkg::box_empty;
			world_pkg::brick_box: return world_pkg::brick;
			default: return world_pkg::box_full; // Question box still full
		endcase
	endfunction

	////////////////////////////////////////
	// Collision query, highest box index wins
	always_comb begin
		wall_hit = (probe_y >= `GROUND_Y) || (probe_x == '0) || (probe_x >= `MAP_WIDTH) ||
			({1'b0, probe_x} + probe_w >= `MAP_WIDTH - 1);
		hit_box = 1'b0;
		hit_index = '0;
		hit_kind = world_pkg::empty_box;
		for (int i = 0; i < `BOX_NUM; i++) begin
			if (box_used(i) && overlap(probe_x, probe_y, probe_w, probe_h,
					box_x[i], box_y[i], tile_sz, tile_sz)) begin
				hit_box = 1'b1;
				hit_index = world_pkg::box_idx_t'(i);
				hit_kind = kind[i];
			end
		end
		blocked = wall_hit | hit_box;
	end

	// Coins under the hero this step
	always_comb begin
		touched_cnt = '0;
		for (int i = 0; i < `COIN_NUM; i++) begin
			touched[i] = coin_present[i] && overlap(hero_x, hero_y, hero_w, hero_h,
				coin_x[i], coin_y[i], tile_sz, tile_sz);
			touched_cnt = touched_cnt + world_pkg::coin_cnt_t'(touched[i]);
		end
	end

	always_ff @(posedge clkdiv) begin
		if (rstn) begin
			for (int i = 0; i < `BOX_NUM; i++)
				kind[i] <= box_init[i];
			coin_present <= '1;
			coin_taken <= '0;
		end else begin
			if (strike)
				kind[strike_index] <= world_pkg::empty_box;
			if (step) begin
				coin_present <= coin_present & ~touched;
				coin_taken <= touched_cnt;
			end else begin
				coin_taken <= '0; // Pulse lasts one cycle
			end
		end
	end

	// Pixel query, boxes drawn over coins
	always_comb begin
		pix_hit = 1'b0;
		pix_tile = world_pkg::sky;
		pix_rel_w = '0;
		pix_rel_h = '0;
		for (int i = 0; i < `COIN_NUM; i++) begin
			if (coin_present[i] && in_tile(pix_x, pix_y, coin_x[i], coin_y[i])) begin
				pix_hit = 1'b1;
				pix_tile = world_pkg::coin;
				pix_rel_w = world_pkg::size_t'(pix_x - coin_x[i]);
				pix_rel_h = world_pkg::size_t'(pix_y + tile_sz - 1'b1 - coin_y[i]);
			end
		end
		for (int i = 0; i < `BOX_NUM; i++) begin
			if (box_used(i) && in_tile(pix_x, pix_y, box_x[i], box_y[i])) begin
				pix_hit = 1'b1;
				pix_tile = box_tile(kind[i]);
				pix_rel_w = world_pkg::size_t'(pix_x - box_x[i]);
				pix_rel_h = world_pkg::size_t'(pix_y + tile_sz - 1'b1 - box_y[i]);
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/hero_motion.sv
`timescale 1ns/100ps
`default_nettype none

`include "world_params.svh"

module hero_motion (
	input wire clkdiv,
	input wire rstn,
	input wire step,
	input wire left_held,
	input wire right_held,
	input wire jump_held,
	output world_pkg::coord_t probe_x,
	output world_pkg::coord_t probe_y,
	output world_pkg::size_t probe_w,
	output world_pkg::size_t probe_h,
	output logic strike,
	output world_pkg::box_idx_t strike_index,
	input wire blocked,
	input wire hit_box,
	input wire world_pkg::box_idx_t hit_index,
	input wire world_pkg::box_kind_e hit_kind,
	input wire world_pkg::coin_cnt_t coin_taken,
	output world_pkg::coord_t hero_x,
	output world_pkg::coord_t hero_y,
	output logic hero_big,
	output world_pkg::size_t hero_h,
	output logic [31:0] score,
	output world_pkg::game_e game
);

	localparam int tick_w = $clog2(`JUMP_LIMIT + 1);
	localparam world_pkg::coord_t start_x = `HERO_START_X;
	localparam world_pkg::coord_t start_y = `HERO_START_Y;
	localparam world_pkg::coord_t castle_x = `CASTLE_X;
	localparam world_pkg::size_t hero_w = `HERO_W;
	localparam world_pkg::size_t h_small = `HERO_H_SMALL;
	localparam world_pkg::size_t h_big = `HERO_H_BIG;

	world_pkg::jump_e jstate;
	logic [tick_w-1:0] jump_ticks;
	logic h_phase; // Horizontal try, cycle after the step
	logic walk_left;
	logic step_live;
	logic strike_hit;
	logic [31:0] bonus;

	assign hero_h = hero_big ? h_big : h_small;
	assign step_live = step && (game == world_pkg::play);

	// Rising into a question box
	assign strike_hit = (jstate == world_pkg::rising) && (jump_ticks != `JUMP_LIMIT) &&
		blocked && hit_box &&
		(hit_kind == world_pkg::coin_box || hit_kind == world_pkg::mushroom_box);

	////////////////////////////////////////
	// One probe port, shared by the two moves of a step
	always_comb begin
		probe_x = hero_x;
		probe_y = hero_y;
		probe_w = hero_w;
		probe_h = hero_h;
		if (h_phase)
			probe_x = walk_left ? hero_x - 1'b1 : hero_x + 1'b1;
		else if (jstate == world_pkg::rising)
			probe_y = hero_y - 1'b1;
		else
			probe_y = hero_y + 1'b1; // Falling, or air check when standing
	end

	always_comb begin
		bonus = '0;
		if (step_live && strike_hit)
			bonus = (hit_kind == world_pkg::mushroom_box) ? `MUSH_PTS : `COIN_PTS;
		if (game == world_pkg::play)
			bonus = bonus + 32'(coin_taken) * `COIN_PTS;
	end

	////////////////////////////////////////
	always_ff @(posedge clkdiv) begin
		if (rstn) begin
			hero_x <= start_x;
			hero_y <= start_y;
			hero_big <= 1'b0;
			jstate <= world_pkg::standing;
			jump_ticks <= '0;
			h_phase <= 1'b0;
			walk_left <= 1'b0;
			strike <= 1'b0;
			strike_index <= '0;
			score <= '0;
			game <= world_pkg::play;
		end else begin
			strike <= 1'b0;
			h_phase <= 1'b0;
			score <= score + bonus;
			if (h_phase && !blocked && game == world_pkg::play)
				hero_x <= probe_x;
			if (step_live) begin
				h_phase <= left_held ^ right_held; // Both buttons cancel out
				walk_left <= left_held;
				if (hero_x + hero_w >= castle_x)
					game <= world_pkg::win;
				case (jstate)
					world_pkg::standing: begin
						if (!blocked) begin
							jstate <= world_pkg::falling; // Air below
						end else if (jump_held) begin
							jstate <= world_pkg::rising;
							jump_ticks <= '0;
						end
					end
					world_pkg::rising: begin
						if (jump_ticks == `JUMP_LIMIT) begin
							jstate <= world_pkg::falling;
						end else begin
							jump_ticks <= jump_ticks + 1'b1;
							if (blocked) begin
								jstate <= world_pkg::falling;
								if (strike_hit) begin
									strike <= 1'b1;
									strike_index <= hit_index;
									// Drop clear of the box before growing
									if (hit_kind == world_pkg::mushroom_box && !hero_big) begin
										hero_y <= hero_y + (h_big - h_small);
										hero_big <= 1'b1;
									end
								end
							end else begin
								hero_y <= probe_y;
							end
						end
					end
					default: begin
						if (blocked)
							jstate <= world_pkg::standing; // Landed
						else
							hero_y <= probe_y;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/pixel_painter.sv
`timescale 1ns/100ps
`default_nettype none

`include "world_params.svh"

module pixel_painter (
	input wire clkdiv,
	input wire rstn,
	input wire [8:0] row_addr,
	input wire [9:0] col_addr,
	input wire world_pkg::coord_t hero_x,
	input wire world_pkg::coord_t hero_y,
	input wire hero_big,
	output world_pkg::coord_t pix_x,
	output world_pkg::coord_t pix_y,
	input wire pix_hit,
	input wire world_pkg::tile_e pix_tile,
	input wire world_pkg::size_t pix_rel_w,
	input wire world_pkg::size_t pix_rel_h,
	output world_pkg::tile_e tile,
	output world_pkg::size_t rel_h,
	output world_pkg::size_t rel_w
);

	localparam world_pkg::coord_t view_left = `VIEW_LEFT;
	localparam world_pkg::coord_t view_max = `MAP_WIDTH - `SCREEN_W;
	localparam world_pkg::size_t hero_w = `HERO_W;

	world_pkg::coord_t view_x;
	world_pkg::size_t hero_h;
	logic hero_in;
	logic castle_in;
	world_pkg::tile_e tile_d;
	world_pkg::size_t rel_h_d;
	world_pkg::size_t rel_w_d;

	// Camera follows the hero, clamped at both map ends
	always_comb begin
		if (hero_x < view_left)
			view_x = '0;
		else if (hero_x - view_left > view_max)
			view_x = view_max;
		else
			view_x = hero_x - view_left;
	end

	////////////////////////////////////////
	// Stage 1, screen to world point
	always_ff @(posedge clkdiv) begin
		pix_x <= world_pkg::coord_t'(col_addr) + view_x;
		pix_y <= world_pkg::coord_t'(row_addr);
	end

	////////////////////////////////////////
	// Stage 2, pick the front object
	assign hero_h = hero_big ? world_pkg::size_t'(`HERO_H_BIG) : world_pkg::size_t'(`HERO_H_SMALL);
	assign hero_in = (pix_y + hero_h > hero_y) && (pix_y <= hero_y) &&
		(pix_x >= hero_x) && (pix_x < hero_x + hero_w);
	assign castle_in = (pix_y + `CASTLE_H > `CASTLE_Y) && (pix_y <= `CASTLE_Y) &&
		(pix_x >= `CASTLE_X) && (pix_x < `CASTLE_X + `CASTLE_W);

	always_comb begin
		if (hero_in) begin
			tile_d = hero_big ? world_pkg::hero_big : world_pkg::hero_small;
			rel_h_d = world_pkg::size_t'(pix_y - hero_y + hero_h - 1'b1);
			rel_w_d = world_pkg::size_t'(pix_x - hero_x);
		end else if (pix_y >= `GROUND_Y) begin
			tile_d = world_pkg::ground;
			rel_h_d = world_pkg::size_t'(pix_y - `GROUND_Y);
			rel_w_d = world_pkg::size_t'(pix_x % `TILE); // Ground tiles repeat
		end else if (castle_in) begin
			tile_d = world_pkg::castle;
			rel_h_d = world_pkg::size_t'(pix_y - `CASTLE_Y + `CASTLE_H - 1);
			rel_w_d = world_pkg::size_t'(pix_x - `CASTLE_X);
		end else if (pix_hit) begin
			tile_d = pix_tile; // Box or coin
			rel_h_d = pix_rel_h;
			rel_w_d = pix_rel_w;
		end else begin
			tile_d = world_pkg::sky;
			rel_h_d = '0;
			rel_w_d = '0;
		end
	end

	always_ff @(posedge clkdiv) begin
		if (rstn) begin
			tile <= world_pkg::sky;
			rel_h <= '0;
			rel_w <= '0;
		end else begin
			tile <= tile_d;
			rel_h <= rel_h_d;
			rel_w <= rel_w_d;
		end
	end

endmodule

`default_nettype wire

// File: logic/world_top.sv
`timescale 1ns/100ps
`default_nettype none

module world_top (
	input wire clkdiv,
	input wire rstn,
	input wire jump,
	input wire left,
	input wire right,
	input wire [8:0] row_addr,
	input wire [9:0] col_addr,
	output wire world_pkg::tile_e tile,
	output wire world_pkg::size_t rel_h,
	output wire world_pkg::size_t rel_w,
	output wire [31:0] score,
	output wire world_pkg::game_e game
);

	// Step timer outputs
	wire step;
	wire left_held;
	wire right_held;
	wire jump_held;

	// Collision probe and box strike
	wire world_pkg::coord_t probe_x;
	wire world_pkg::coord_t probe_y;
	wire world_pkg::size_t probe_w;
	wire world_pkg::size_t probe_h;
	wire blocked;
	wire hit_box;
	wire world_pkg::box_idx_t hit_index;
	wire world_pkg::box_kind_e hit_kind;
	wire strike;
	wire world_pkg::box_idx_t strike_index;

	// Hero state and coins
	wire world_pkg::coord_t hero_x;
	wire world_pkg::coord_t hero_y;
	wire world_pkg::size_t hero_h;
	wire hero_big;
	wire world_pkg::coin_cnt_t coin_taken;

	// Pixel lookups
	wire world_pkg::coord_t pix_x;
	wire world_pkg::coord_t pix_y;
	wire pix_hit;
	wire world_pkg::tile_e pix_tile;
	wire world_pkg::size_t pix_rel_w;
	wire world_pkg::size_t pix_rel_h;

	step_timer u_step_timer (
		.clkdiv(clkdiv), .rstn(rstn),
		.jump(jump), .left(left), .right(right),
		.step(step), .left_held(left_held), .right_held(right_held), .jump_held(jump_held)
	);

	stage_layout u_stage_layout (
		.clkdiv(clkdiv), .rstn(rstn),
		.probe_x(probe_x), .probe_y(probe_y), .probe_w(probe_w), .probe_h(probe_h),
		.blocked(blocked), .hit_box(hit_box), .hit_index(hit_index), .hit_kind(hit_kind),
		.strike(strike), .strike_index(strike_index), .step(step),
		.hero_x(hero_x), .hero_y(hero_y), .hero_h(hero_h), .coin_taken(coin_taken),
		.pix_x(pix_x), .pix_y(pix_y), .pix_hit(pix_hit), .pix_tile(pix_tile),
		.pix_rel_w(pix_rel_w), .pix_rel_h(pix_rel_h)
	);

	hero_motion u_hero_motion (
		.clkdiv(clkdiv), .rstn(rstn), .step(step),
		.left_held(left_held), .right_held(right_held), .jump_held(jump_held),
		.probe_x(probe_x), .probe_y(probe_y), .probe_w(probe_w), .probe_h(probe_h),
		.strike(strike), .strike_index(strike_index),
		.blocked(blocked), .hit_box(hit_box), .hit_index(hit_index), .hit_kind(hit_kind),
		.coin_taken(coin_taken),
		.hero_x(hero_x), .hero_y(hero_y), .hero_big(hero_big), .hero_h(hero_h),
		.score(score), .game(game)
	);

	pixel_painter u_pixel_painter (
		.clkdiv(clkdiv), .rstn(rstn),
		.row_addr(row_addr), .col_addr(col_addr),
		.hero_x(hero_x), .hero_y(hero_y), .hero_big(hero_big),
		.pix_x(pix_x), .pix_y(pix_y),
		.pix_hit(pix_hit), .pix_tile(pix_tile), .pix_rel_w(pix_rel_w), .pix_rel_h(pix_rel_h),
		.tile(tile), .rel_h(rel_h), .rel_w(rel_w)
	);

endmodule

`default_nettype wire

// File: bench/world_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module world_assertions (
	input wire clkdiv,
	input wire rstn,
	input wire [31:0] score,
	input wire world_pkg::game_e game,
	input wire step
);

	////////////////////////////////////////
	// Score only grows between resets
	a_score_up: assert property (@(posedge clkdiv)
		(!rstn && !$past(rstn)) |-> (score >= $past(score)))
		else $error("score went down without a reset");

	// Win is final until reset
	a_win_holds: assert property (@(posedge clkdiv)
		(!rstn && !$past(rstn) && $past(game) == world_pkg::win) |-> (game == world_pkg::win))
		else $error("game left the win state without a reset");

	// Step is a single cycle pulse
	a_step_pulse: assert property (@(posedge clkdiv)
		step |=> !step)
		else $error("step stayed high for two cycles");

endmodule

bind world_top world_assertions u_world_assertions (
	.clkdiv(clkdiv),
	.rstn(rstn),
	.score(score),
	.game(game),
	.step(step)
);

`default_nettype wire

// File: bench/world_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "world_params.svh"

module world_tb;

	logic clkdiv;
	logic rstn;
	logic jump;
	logic left;
	logic right;
	logic [8:0] row_addr;
	logic [9:0] col_addr;
	world_pkg::tile_e tile;
	world_pkg::size_t rel_h;
	world_pkg::size_t rel_w;
	logic [31:0] score;
	world_pkg::game_e game;

	int mismatches;
	int timeouts;

	world_top u_dut (
		.clkdiv(clkdiv),
		.rstn(rstn),
		.jump(jump),
		.left(left),
		.right(right),
		.row_addr(row_addr),
		.col_addr(col_addr),
		.tile(tile),
		.rel_h(rel_h),
		.rel_w(rel_w),
		.score(score),
		.game(game)
	);

	always #10 clkdiv = ~clkdiv; // 20 ns period

	////////////////////////////////////////
	// Compare tasks
	task automatic check_tile(input string name, input world_pkg::tile_e exp,
		input world_pkg::tile_e act);
		if (exp !== act) begin
			$display("Mismatch %s: tile expected %0d actual %0d", name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_size(input string name, input world_pkg::size_t exp,
		input world_pkg::size_t act);
		if (exp !== act) begin
			$display("Mismatch %s: offset expected %0d actual %0d", name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_score(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("Mismatch %s: score expected %0d actual %0d", name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_game(input string name, input world_pkg::game_e exp,
		input world_pkg::game_e act);
		if (exp !== act) begin
			$display("Mismatch %s: game expected %0d actual %0d", name, exp, act);
			mismatches++;
		end
	endtask

	////////////////////////////////////////
	// Stimulus helpers drive on the falling edge
	task automatic press_buttons(input int mask);
		@(negedge clkdiv);
		jump = mask[2];
		left = mask[1];
		right = mask[0];
	endtask

	task automatic apply_reset();
		@(negedge clkdiv);
		jump = 1'b0;
		left = 1'b0;
		right = 1'b0;
		rstn = 1'b1;
		repeat (4) @(negedge clkdiv);
		rstn = 1'b0;
	endtask

	task automatic probe_pixel(input string name, input int row, input int col,
		input int exp_tile, input int exp_h, input int exp_w);
		@(negedge clkdiv);
		row_addr = 9'(row);
		col_addr = 10'(col);
		repeat (2) @(posedge clkdiv); // Two pipeline stages
		@(negedge clkdiv);
		check_tile(name, world_pkg::tile_e'(exp_tile), tile);
		check_size({name, "/rel_h"}, world_pkg::size_t'(exp_h), rel_h);
		check_size({name, "/rel_w"}, world_pkg::size_t'(exp_w), rel_w);
	endtask

	task automatic hold_steps(input int mask, input int steps);
		press_buttons(mask);
		for (int i = 0; i < steps * `STEP_DIV; i++)
			@(negedge clkdiv);
		press_buttons(0);
	endtask

	task automatic wait_score(input string name, input int mask, input int steps,
		input int value);
		int limit;
		bit found;
		limit = (steps + 2) * `STEP_DIV;
		found = 1'b0;
		press_buttons(mask);
		for (int i = 0; i < limit && !found; i++) begin
			if (score == value)
				found = 1'b1;
			else
				@(negedge clkdiv);
		end
		press_buttons(0);
		if (!found) begin
			$display("%s: score did not reach %0d within %0d steps", name, value, steps);
			timeouts++;
		end
		check_score(name, value, score);
	endtask

	task automatic wait_game(input string name, input int mask, input int steps,
		input int value);
		int limit;
		bit found;
		limit = (steps + 2) * `STEP_DIV;
		found = 1'b0;
		press_buttons(mask);
		for (int i = 0; i < limit && !found; i++) begin
			if (game == world_pkg::game_e'(value))
				found = 1'b1;
			else
				@(negedge clkdiv);
		end
		press_buttons(0);
		if (!found) begin
			$display("%s: game state did not become %0d within %0d steps", name, value, steps);
			timeouts++;
		end
		check_game(name, world_pkg::game_e'(value), game);
	endtask

	////////////////////////////////////////
	// Test data interpreter
	initial begin
		int fd;
		int r;
		int a;
		int b;
		int c;
		int d;
		int e;
		string name;
		string op;
		string line;
		clkdiv = 1'b0;
		rstn = 1'b1;
		jump = 1'b0;
		left = 1'b0;
		right = 1'b0;
		row_addr = '0;
		col_addr = '0;
		mismatches = 0;
		timeouts = 0;
		fd = $fopen("bench/world_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file");
			$display("TESTS FAILED");
			$finish;
		end else begin
			apply_reset();
			while (!$feof(fd)) begin
				r = $fscanf(fd, "%s", name);
				if (r != 1)
					break;
				if (name[0] == 8'h23) begin
					r = $fgets(line, fd); // Comment line
					continue;
				end
				r = $fscanf(fd, "%s", op);
				case (op)
					"R": apply_reset();
					"P": begin
						r = $fscanf(fd, "%d %d %d %d %d", a, b, c, d, e);
						probe_pixel(name, a, b, c, d, e);
					end
					"S": begin
						r = $fscanf(fd, "%d %d %d", a, b, c);
						wait_score(name, a, b, c);
					end
					"G": begin
						r = $fscanf(fd, "%d %d %d", a, b, c);
						wait_game(name, a, b, c);
					end
					"W": begin
						r = $fscanf(fd, "%d %d", a, b);
						hold_steps(a, b);
					end
					default: begin
						$display("%s: unknown opcode %s in the test data", name, op);
						mismatches++;
						r = $fgets(line, fd);
					end
				endcase
			end
			$fclose(fd);
			$display("Checks done with %0d mismatches and %0d timeouts", mismatches, timeouts);
			if (mismatches == 0 && timeouts == 0)
				$display("TESTS PASSED");
			else
				$display("TESTS FAILED");
			$finish;
		end
	end

	// Guard against a stuck run
	initial begin
		repeat (100000) @(posedge clkdiv);
		$display("Simulation ran too long and was stopped");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/world_testdata.txt
# name op args; R reset, P row col tile rel_h rel_w, W buttons steps
# S buttons steps score, G buttons steps game; buttons 4 jump 2 left 1 right
start R
ground_px P 450 45 13 10 5
box_px P 270 210 0 9 10
sky_px P 10 10 63 0 0
coin_pick S 1 80 5
coin_gone P 420 190 63 0 0
walk_box W 1 60
coin_box S 4 300 10
box_spent P 270 210 1 9 10
second_jump W 4 250
jump_again S 0 1 10
settle_a W 0 150
walk_mush W 1 210
mush_box S 4 300 30
settle_b W 0 100
hero_grown P 379 315 3 19 5
castle G 1 1500 1
after_win W 1 50
score_kept S 0 1 45
restart R
walk_again S 1 80 5
mid_reset R
score_clear S 0 1 0
game_clear G 0 1 0
box_restored P 270 210 0 9 10

// File: list.f
+incdir+logic
logic/world_pkg.sv
logic/step_timer.sv
logic/stage_layout.sv
logic/hero_motion.sv
logic/pixel_painter.sv
logic/world_top.sv
bench/world_assertions.sv
bench/world_tb.sv

// File: Makefile
TOP = world_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

obj_dir/V$(TOP): list.f $(wildcard logic/*) $(wildcard bench/*)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
